//--- include/memory_accessors_settings.svh
`ifndef MEMORY_ACCESSORS_SETTINGS_SVH
`define MEMORY_ACCESSORS_SETTINGS_SVH

// Byte address width
`define MA_ADDR_WIDTH 32

// One memory line, also one LAR's data
`define MA_LINE_WIDTH 64

// Low address bits inside a line
`define MA_LINE_OFFSET_WIDTH 3

// Two instructions per line
`define MA_INSTR_WIDTH 32

// Direct-mapped instruction cache size in lines
`define MA_ICACHE_LINES 4

`define MA_NUM_LARS 8

`endif

//--- verilog/pkg_cpu_types.sv
`include "memory_accessors_settings.svh"

package pkg_cpu_types;

	// Byte address
	typedef logic [`MA_ADDR_WIDTH-1:0] cpu_addr;

	// One line, as seen by memory and by a LAR
	typedef logic [`MA_LINE_WIDTH-1:0] line_data;

	typedef logic [`MA_INSTR_WIDTH-1:0] instr_word;

	// Selects one of the LARs
	typedef logic [$clog2(`MA_NUM_LARS)-1:0] lar_index;

	// LAR write port operation
	// Load pulls a new line from memory, store only touches data
	typedef enum logic {
		lar_op_load,
		lar_op_store
	} lar_op;

endpackage

//--- verilog/pkg_mem_bus.sv
package pkg_mem_bus;

	// Current bus owner
	// Declaration order follows the guard's priority
	typedef enum logic [1:0] {
		req_none,
		req_data_write,
		req_data_read,
		req_instr
	} mem_requester;

	// Operation carried with mem_req
	typedef enum logic {
		bus_op_read,
		bus_op_write
	} mem_bus_op;

	// Guard FSM
	typedef enum logic {
		guard_idle,
		guard_wait_ack
	} guard_state;

endpackage

//--- verilog/instr_cache.sv
`timescale 1ns/1ps
`include "memory_accessors_settings.svh"

module instr_cache (
	input logic clk,
	input logic reset,
	input logic fetch_req,
	input pkg_cpu_types::cpu_addr fetch_addr,
	output logic fetch_valid,
	output pkg_cpu_types::instr_word fetch_instr,
	output logic fetch_busy,
	output logic fill_req,
	output pkg_cpu_types::cpu_addr fill_addr,
	input logic fill_done,
	input pkg_cpu_types::line_data fill_data
);
	import pkg_cpu_types::*;

	localparam int index_width = $clog2(`MA_ICACHE_LINES);
	localparam int tag_lsb = `MA_LINE_OFFSET_WIDTH + index_width;
	localparam int tag_width = `MA_ADDR_WIDTH - tag_lsb;
	// Address bit 2 picks the upper instruction
	localparam int half_bit = `MA_LINE_OFFSET_WIDTH - 1;

	typedef enum logic {
		cache_ready,
		cache_fill
	} cache_state;

	cache_state state;
	line_data lines [`MA_ICACHE_LINES];
	logic [tag_width-1:0] tags [`MA_ICACHE_LINES];
	logic [`MA_ICACHE_LINES-1:0] valid;
	cpu_addr miss_addr;

	logic [index_width-1:0] fetch_index;
	logic [index_width-1:0] miss_index;
	logic [tag_width-1:0] fetch_tag;
	logic hit;

	// Upper or lower half of a line
	function automatic instr_word pick_instr(input line_data line, input logic upper);
		return upper ? line[2*`MA_INSTR_WIDTH-1:`MA_INSTR_WIDTH] : line[`MA_INSTR_WIDTH-1:0];
	endfunction

	assign fetch_index = fetch_addr[tag_lsb-1:`MA_LINE_OFFSET_WIDTH];
	assign fetch_tag = fetch_addr[`MA_ADDR_WIDTH-1:tag_lsb];
	assign miss_index = miss_addr[tag_lsb-1:`MA_LINE_OFFSET_WIDTH];
	assign hit = valid[fetch_index] && (tags[fetch_index] == fetch_tag);

	// Busy and fill request are the same level, held until fill_done
	assign fetch_busy = (state == cache_fill);
	assign fill_req = (state == cache_fill);
	// Line aligned
	assign fill_addr = {miss_addr[`MA_ADDR_WIDTH-1:`MA_LINE_OFFSET_WIDTH],
		{`MA_LINE_OFFSET_WIDTH{1'b0}}};

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= cache_ready;
			valid <= '0;
			fetch_valid <= 1'b0;
		end else begin
			fetch_valid <= 1'b0;
			case (state)
			cache_ready: begin
				// Hit answers next cycle, miss starts a fill
				if (fetch_req && hit) begin
					fetch_valid <= 1'b1;
				end else if (fetch_req) begin
					state <= cache_fill;
				end
			end
			cache_fill: begin
				if (fill_done) begin
					valid[miss_index] <= 1'b1;
					fetch_valid <= 1'b1;
					state <= cache_ready;
				end
			end
			default: state <= cache_ready;
			endcase
		end
	end

	// Line storage and answer data
	always_ff @(posedge clk) begin
		if (state == cache_ready && fetch_req) begin
			miss_addr <= fetch_addr;
			fetch_instr <= pick_instr(lines[fetch_index], fetch_addr[half_bit]);
		end
		if (state == cache_fill && fill_done) begin
			lines[miss_index] <= fill_data;
			tags[miss_index] <= miss_addr[`MA_ADDR_WIDTH-1:tag_lsb];
			// Answer straight from the incoming line
			fetch_instr <= pick_instr(fill_data, miss_addr[half_bit]);
		end
	end

endmodule

//--- verilog/lar_file.sv
`timescale 1ns/1ps
`include "memory_accessors_settings.svh"

module lar_file (
	input logic clk,
	input logic reset,
	input logic lar_wr,
	input pkg_cpu_types::lar_op lar_wr_op,
	input pkg_cpu_types::lar_index lar_wr_index,
	input pkg_cpu_types::cpu_addr lar_wr_addr,
	input pkg_cpu_types::line_data lar_wr_data,
	output logic lar_wr_done,
	output logic lar_busy,
	input pkg_cpu_types::lar_index rd_index_a,
	input pkg_cpu_types::lar_index rd_index_b,
	input pkg_cpu_types::lar_index rd_index_c,
	output pkg_cpu_types::cpu_addr rd_base_a,
	output pkg_cpu_types::cpu_addr rd_base_b,
	output pkg_cpu_types::cpu_addr rd_base_c,
	output pkg_cpu_types::line_data rd_data_a,
	output pkg_cpu_types::line_data rd_data_b,
	output pkg_cpu_types::line_data rd_data_c,
	output logic rd_dirty_a,
	output logic rd_dirty_b,
	output logic rd_dirty_c,
	output logic rd_req,
	output pkg_cpu_types::cpu_addr rd_addr,
	output logic wb_req,
	output pkg_cpu_types::cpu_addr wb_addr,
	output pkg_cpu_types::line_data wb_data,
	input logic rd_done,
	input pkg_cpu_types::line_data rd_data,
	input logic wb_done
);
	import pkg_cpu_types::*;

	// Load sequencer
	typedef enum logic [1:0] {
		seq_idle,
		seq_write_back,
		seq_read
	} seq_state;

	seq_state state;
	cpu_addr lar_base [`MA_NUM_LARS];
	line_data lar_data [`MA_NUM_LARS];
	logic [`MA_NUM_LARS-1:0] lar_dirty;

	// Pending load
	lar_index load_index;
	cpu_addr load_addr;
	cpu_addr aligned_addr;

	assign aligned_addr = {lar_wr_addr[`MA_ADDR_WIDTH-1:`MA_LINE_OFFSET_WIDTH],
		{`MA_LINE_OFFSET_WIDTH{1'b0}}};

	assign lar_busy = (state != seq_idle);

	// Entry stays untouched during the load, so the old line is read in place
	assign wb_req = (state == seq_write_back);
	assign wb_addr = lar_base[load_index];
	assign wb_data = lar_data[load_index];
	assign rd_req = (state == seq_read);
	assign rd_addr = load_addr;

	// Combinational read ports
	assign rd_base_a = lar_base[rd_index_a];
	assign rd_base_b = lar_base[rd_index_b];
	assign rd_base_c = lar_base[rd_index_c];
	assign rd_data_a = lar_data[rd_index_a];
	assign rd_data_b = lar_data[rd_index_b];
	assign rd_data_c = lar_data[rd_index_c];
	assign rd_dirty_a = lar_dirty[rd_index_a];
	assign rd_dirty_b = lar_dirty[rd_index_b];
	assign rd_dirty_c = lar_dirty[rd_index_c];

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= seq_idle;
			lar_wr_done <= 1'b0;
			lar_dirty <= '0;
			// All entries clean and zero
			for (int i = 0; i < `MA_NUM_LARS; i++) begin
				lar_base[i] <= '0;
				lar_data[i] <= '0;
			end
		end else begin
			lar_wr_done <= 1'b0;
			case (state)
			seq_idle: begin
				if (lar_wr) begin
					case (lar_wr_op)
					lar_op_store: begin
						// Single cycle, base unchanged
						lar_data[lar_wr_index] <= lar_wr_data;
						lar_dirty[lar_wr_index] <= 1'b1;
						lar_wr_done <= 1'b1;
					end
					lar_op_load: begin
						// Dirty line goes out first
						if (lar_dirty[lar_wr_index]) begin
							state <= seq_write_back;
						end else begin
							state <= seq_read;
						end
					end
					default: state <= seq_idle;
					endcase
				end
			end
			seq_write_back: begin
				if (wb_done) begin
					lar_dirty[load_index] <= 1'b0;
					state <= seq_read;
				end
			end
			seq_read: begin
				if (rd_done) begin
					lar_base[load_index] <= load_addr;
					lar_data[load_index] <= rd_data;
					lar_dirty[load_index] <= 1'b0;
					lar_wr_done <= 1'b1;
					state <= seq_idle;
				end
			end
			default: state <= seq_idle;
			endcase
		end
	end

	// Capture target of an accepted write
	always_ff @(posedge clk) begin
		if (state == seq_idle && lar_wr) begin
			load_index <= lar_wr_index;
			load_addr <= aligned_addr;
		end
	end

endmodule

//--- verilog/mem_bus_guard.sv
`timescale 1ns/1ps

module mem_bus_guard (
	input logic clk,
	input logic reset,
	input logic fill_req,
	input pkg_cpu_types::cpu_addr fill_addr,
	input logic rd_req,
	input pkg_cpu_types::cpu_addr rd_addr,
	input logic wb_req,
	input pkg_cpu_types::cpu_addr wb_addr,
	input pkg_cpu_types::line_data wb_data,
	output logic fill_done,
	output pkg_cpu_types::line_data fill_data,
	output logic rd_done,
	output pkg_cpu_types::line_data rd_data,
	output logic wb_done,
	output logic mem_req,
	output pkg_mem_bus::mem_bus_op mem_op,
	output pkg_cpu_types::cpu_addr mem_addr,
	output pkg_cpu_types::line_data mem_wdata,
	input logic mem_ack,
	input pkg_cpu_types::line_data mem_rdata
);
	import pkg_mem_bus::*;

	guard_state state;
	mem_requester owner;
	mem_requester winner;
	logic ack_seen;

	// Fixed priority of write-back over line read over fill
	always_comb begin
		winner = req_none;
		if (wb_req) begin
			winner = req_data_write;
		end else if (rd_req) begin
			winner = req_data_read;
		end else if (fill_req) begin
			winner = req_instr;
		end
	end

	assign ack_seen = mem_ack && (state == guard_wait_ack);

	// Done pulses line up with mem_ack
	assign wb_done = ack_seen && (owner == req_data_write);
	assign rd_done = ack_seen && (owner == req_data_read);
	assign fill_done = ack_seen && (owner == req_instr);
	// Read data passes through, only the matching done matters
	assign rd_data = mem_rdata;
	assign fill_data = mem_rdata;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= guard_idle;
			owner <= req_none;
			mem_req <= 1'b0;
		end else begin
			// mem_req is a one cycle pulse
			mem_req <= 1'b0;
			case (state)
			guard_idle: begin
				if (winner != req_none) begin
					owner <= winner;
					mem_req <= 1'b1;
					state <= guard_wait_ack;
				end
			end
			guard_wait_ack: begin
				// Requester drops its level next cycle
				if (mem_ack) begin
					owner <= req_none;
					state <= guard_idle;
				end
			end
			default: state <= guard_idle;
			endcase
		end
	end

	// Bus payload latched with the accept
	always_ff @(posedge clk) begin
		if (state == guard_idle) begin
			case (winner)
			req_data_write: begin
				mem_op <= bus_op_write;
				mem_addr <= wb_addr;
				mem_wdata <= wb_data;
			end
			req_data_read: begin
				mem_op <= bus_op_read;
				mem_addr <= rd_addr;
			end
			default: begin
				mem_op <= bus_op_read;
				mem_addr <= fill_addr;
			end
			endcase
		end
	end

endmodule

//--- verilog/memory_accessors.sv
`timescale 1ns/1ps

module memory_accessors (
	input logic clk,
	input logic reset,
	input logic fetch_req,
	input pkg_cpu_types::cpu_addr fetch_addr,
	output logic fetch_valid,
	output pkg_cpu_types::instr_word fetch_instr,
	output logic fetch_busy,
	input logic lar_wr,
	input pkg_cpu_types::lar_op lar_wr_op,
	input pkg_cpu_types::lar_index lar_wr_index,
	input pkg_cpu_types::cpu_addr lar_wr_addr,
	input pkg_cpu_types::line_data lar_wr_data,
	output logic lar_wr_done,
	output logic lar_busy,
	input pkg_cpu_types::lar_index rd_index_a,
	input pkg_cpu_types::lar_index rd_index_b,
	input pkg_cpu_types::lar_index rd_index_c,
	output pkg_cpu_types::cpu_addr rd_base_a,
	output pkg_cpu_types::cpu_addr rd_base_b,
	output pkg_cpu_types::cpu_addr rd_base_c,
	output pkg_cpu_types::line_data rd_data_a,
	output pkg_cpu_types::line_data rd_data_b,
	output pkg_cpu_types::line_data rd_data_c,
	output logic rd_dirty_a,
	output logic rd_dirty_b,
	output logic rd_dirty_c,
	output logic mem_req,
	output pkg_mem_bus::mem_bus_op mem_op,
	output pkg_cpu_types::cpu_addr mem_addr,
	output pkg_cpu_types::line_data mem_wdata,
	input logic mem_ack,
	input pkg_cpu_types::line_data mem_rdata
);
	import pkg_cpu_types::*;

	// Cache fill path
	logic fill_req;
	cpu_addr fill_addr;
	logic fill_done;
	line_data fill_data;

	// LAR line read and write-back paths
	logic rd_req;
	cpu_addr rd_addr;
	logic rd_done;
	line_data rd_data;
	logic wb_req;
	cpu_addr wb_addr;
	line_data wb_data;
	logic wb_done;

	// Port names match the nets above
	instr_cache instr_cache_inst (.*);

	lar_file lar_file_inst (.*);

	// Single owner of the external bus
	mem_bus_guard mem_bus_guard_inst (.*);

endmodule

//--- sim/memory_accessors_tb.sv
`timescale 1ns/1ps

module memory_accessors_tb;
	import pkg_cpu_types::*;
	import pkg_mem_bus::*;

	// Unwritten memory lines read as line address times this odd constant
	localparam logic [63:0] fill_mult = 64'h9e37_79b9_7f4a_7c15;
	localparam int wait_limit = 200;

	logic clk = 1'b0;
	logic reset;
	logic fetch_req;
	cpu_addr fetch_addr;
	logic fetch_valid;
	instr_word fetch_instr;
	logic fetch_busy;
	logic lar_wr;
	lar_op lar_wr_op;
	lar_index lar_wr_index;
	cpu_addr lar_wr_addr;
	line_data lar_wr_data;
	logic lar_wr_done;
	logic lar_busy;
	lar_index rd_index_a;
	lar_index rd_index_b;
	lar_index rd_index_c;
	cpu_addr rd_base_a;
	cpu_addr rd_base_b;
	cpu_addr rd_base_c;
	line_data rd_data_a;
	line_data rd_data_b;
	line_data rd_data_c;
	logic rd_dirty_a;
	logic rd_dirty_b;
	logic rd_dirty_c;
	logic mem_req;
	mem_bus_op mem_op;
	cpu_addr mem_addr;
	line_data mem_wdata;
	logic mem_ack;
	line_data mem_rdata;

	// Memory contents that were written, and every finished bus transaction in order
	line_data mem_store [cpu_addr];
	mem_bus_op log_op [$];
	cpu_addr log_addr [$];
	line_data log_data [$];

	int check_errors = 0;
	int req_pulse_errors = 0;
	int done_pulse_errors = 0;
	int checks = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int test_start_errors;
	string test_name;

	memory_accessors dut (.*);

	always #2 clk = ~clk;

	// Bus request lasts one cycle
	req_pulse: assert property (@(posedge clk) disable iff (reset) mem_req |=> !mem_req)
	else begin
		$display("mem_req stayed high for more than one cycle at %0t", $time);
		req_pulse_errors++;
	end

	done_pulse: assert property (@(posedge clk) disable iff (reset) lar_wr_done |=> !lar_wr_done)
	else begin
		$display("lar_wr_done stayed high for more than one cycle at %0t", $time);
		done_pulse_errors++;
	end

	function automatic line_data model_line(input cpu_addr addr);
		if (mem_store.exists(addr)) begin
			return mem_store[addr];
		end
		return 64'(addr) * fill_mult;
	endfunction

	function automatic int total_errors();
		return check_errors + req_pulse_errors + done_pulse_errors;
	endfunction

	// Memory model answering after 1 to 4 cycles
	initial begin
		int delay;
		mem_bus_op op;
		cpu_addr addr;
		line_data wdata;
		mem_ack = 1'b0;
		mem_rdata = '0;
		void'($urandom(32'h8fd5c4db));
		forever begin
			@(negedge clk);
			if (mem_req) begin
				op = mem_op;
				addr = mem_addr;
				wdata = mem_wdata;
				delay = int'($urandom % 4) + 1;
				repeat (delay) @(posedge clk);
				#1;
				mem_ack = 1'b1;
				log_op.push_back(op);
				log_addr.push_back(addr);
				if (op == bus_op_write) begin
					mem_store[addr] = wdata;
					mem_rdata = '0;
					log_data.push_back(wdata);
				end else begin
					mem_rdata = model_line(addr);
					log_data.push_back(mem_rdata);
				end
				@(posedge clk);
				#1;
				mem_ack = 1'b0;
			end
		end
	end

	task automatic check_value(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		checks++;
		value_match: assert (actual === expected)
		else begin
			$display("Error %s %s: expected %h, actual %h", test_name, what, expected, actual);
			check_errors++;
		end
	endtask

	task automatic stop_on_timeout(input string what);
		$display("Timeout in %s: %s", test_name, what);
		$display("Simulation FAILED");
		$finish;
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_start_errors = total_errors();
		tests_run++;
	endtask

	task automatic end_test();
		if (total_errors() == test_start_errors) begin
			$display("Test %s: ok", test_name);
		end else begin
			$display("Test %s: %0d errors", test_name, total_errors() - test_start_errors);
			tests_failed++;
		end
	endtask

	// One fetch pulse, then wait for the answer
	task automatic fetch(input cpu_addr addr, output instr_word instr, output int cycles,
		output logic busy_seen);
		@(posedge clk);
		#1;
		fetch_req = 1'b1;
		fetch_addr = addr;
		@(posedge clk);
		#1;
		fetch_req = 1'b0;
		cycles = 1;
		@(negedge clk);
		busy_seen = fetch_busy;
		while (!fetch_valid && cycles < wait_limit) begin
			@(negedge clk);
			cycles++;
		end
		if (!fetch_valid) begin
			stop_on_timeout("fetch_valid never pulsed");
		end else begin
			instr = fetch_instr;
		end
	endtask

	task automatic lar_write(input lar_op op, input lar_index index, input cpu_addr addr,
		input line_data data, output int cycles, output logic busy_seen);
		@(posedge clk);
		#1;
		lar_wr = 1'b1;
		lar_wr_op = op;
		lar_wr_index = index;
		lar_wr_addr = addr;
		lar_wr_data = data;
		@(posedge clk);
		#1;
		lar_wr = 1'b0;
		cycles = 1;
		@(negedge clk);
		busy_seen = lar_busy;
		while (!lar_wr_done && cycles < wait_limit) begin
			@(negedge clk);
			cycles++;
		end
		if (!lar_wr_done) begin
			stop_on_timeout("lar_wr_done never pulsed");
		end
	endtask

	// All three read ports on one entry
	task automatic check_entry(input lar_index index, input cpu_addr base, input line_data data,
		input logic dirty);
		@(posedge clk);
		#1;
		rd_index_a = index;
		rd_index_b = index;
		rd_index_c = index;
		@(negedge clk);
		check_value("base a", 64'(base), 64'(rd_base_a));
		check_value("base b", 64'(base), 64'(rd_base_b));
		check_value("base c", 64'(base), 64'(rd_base_c));
		check_value("data a", data, rd_data_a);
		check_value("data b", data, rd_data_b);
		check_value("data c", data, rd_data_c);
		check_value("dirty a", 64'(dirty), 64'(rd_dirty_a));
		check_value("dirty b", 64'(dirty), 64'(rd_dirty_b));
		check_value("dirty c", 64'(dirty), 64'(rd_dirty_c));
	endtask

	task automatic check_bus(input int pos, input mem_bus_op op, input cpu_addr addr,
		input line_data data);
		if (pos < log_op.size()) begin
			check_value("bus op", 64'(op), 64'(log_op[pos]));
			check_value("bus addr", 64'(addr), 64'(log_addr[pos]));
			// Write data is what the DUT drove on mem_wdata
			if (op == bus_op_write) begin
				check_value("bus data", data, log_data[pos]);
			end
		end
	endtask

	initial begin
		instr_word instr;
		int cycles;
		logic busy_seen;
		int lar_cycles;
		logic lar_busy_seen;
		int log_start;
		line_data line;
		line_data store_data;
		reset = 1'b1;
		fetch_req = 1'b0;
		fetch_addr = '0;
		lar_wr = 1'b0;
		lar_wr_op = lar_op_load;
		lar_wr_index = '0;
		lar_wr_addr = '0;
		lar_wr_data = '0;
		rd_index_a = '0;
		rd_index_b = '0;
		rd_index_c = '0;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;

		begin_test("reset_state");
		@(negedge clk);
		check_value("mem_req", 64'(1'b0), 64'(mem_req));
		check_value("fetch_valid", 64'(1'b0), 64'(fetch_valid));
		check_value("fetch_busy", 64'(1'b0), 64'(fetch_busy));
		check_value("lar_busy", 64'(1'b0), 64'(lar_busy));
		check_value("lar_wr_done", 64'(1'b0), 64'(lar_wr_done));
		for (int i = 0; i < 8; i++) begin
			check_entry(lar_index'(i), '0, '0, 1'b0);
		end
		end_test();

		// Miss on upper half, then hit on lower half of the same line
		begin_test("fetch_miss_then_hit");
		log_start = log_op.size();
		fetch(32'h0000_1004, instr, cycles, busy_seen);
		line = model_line(32'h0000_1000);
		check_value("miss busy", 64'(1'b1), 64'(busy_seen));
		check_value("miss instr", 64'(line[63:32]), 64'(instr));
		check_value("miss bus count", 64'(log_start + 1), 64'(log_op.size()));
		check_bus(log_start, bus_op_read, 32'h0000_1000, line);
		log_start = log_op.size();
		fetch(32'h0000_1000, instr, cycles, busy_seen);
		check_value("hit latency", 64'(1), 64'(cycles));
		check_value("hit busy", 64'(1'b0), 64'(busy_seen));
		check_value("hit instr", 64'(line[31:0]), 64'(instr));
		// Long enough for any stray request to be answered
		repeat (8) @(negedge clk);
		check_value("hit bus count", 64'(log_start), 64'(log_op.size()));
		end_test();

		begin_test("lar_load_clean");
		log_start = log_op.size();
		lar_write(lar_op_load, 3'd2, 32'h0000_2a6d, '0, lar_cycles, lar_busy_seen);
		line = model_line(32'h0000_2a68);
		check_value("load busy", 64'(1'b1), 64'(lar_busy_seen));
		check_value("load bus count", 64'(log_start + 1), 64'(log_op.size()));
		check_bus(log_start, bus_op_read, 32'h0000_2a68, line);
		check_entry(3'd2, 32'h0000_2a68, line, 1'b0);
		end_test();

		// Store, then reload forces write-back of the stored line
		begin_test("lar_store_write_back");
		store_data = 64'hdead_beef_0123_4567;
		lar_write(lar_op_store, 3'd2, '0, store_data, lar_cycles, lar_busy_seen);
		check_value("store latency", 64'(1), 64'(lar_cycles));
		check_entry(3'd2, 32'h0000_2a68, store_data, 1'b1);
		log_start = log_op.size();
		lar_write(lar_op_load, 3'd2, 32'h0000_3c10, '0, lar_cycles, lar_busy_seen);
		line = model_line(32'h0000_3c10);
		check_value("reload bus count", 64'(log_start + 2), 64'(log_op.size()));
		check_bus(log_start, bus_op_write, 32'h0000_2a68, store_data);
		check_bus(log_start + 1, bus_op_read, 32'h0000_3c10, line);
		check_value("memory holds store", store_data, model_line(32'h0000_2a68));
		check_entry(3'd2, 32'h0000_3c10, line, 1'b0);
		end_test();

		// Fetch miss and dirty reload raised together
		begin_test("bus_priority");
		store_data = 64'h0123_4567_89ab_cdef;
		lar_write(lar_op_store, 3'd5, '0, store_data, lar_cycles, lar_busy_seen);
		log_start = log_op.size();
		fork
			fetch(32'h0000_5000, instr, cycles, busy_seen);
			lar_write(lar_op_load, 3'd5, 32'h0000_6008, '0, lar_cycles, lar_busy_seen);
		join
		line = model_line(32'h0000_6008);
		check_value("priority bus count", 64'(log_start + 3), 64'(log_op.size()));
		check_bus(log_start, bus_op_write, 32'h0000_0000, store_data);
		check_bus(log_start + 1, bus_op_read, 32'h0000_6008, line);
		check_bus(log_start + 2, bus_op_read, 32'h0000_5000, model_line(32'h0000_5000));
		check_value("fill instr", 64'(model_line(32'h0000_5000) & 64'hffff_ffff), 64'(instr));
		check_entry(3'd5, 32'h0000_6008, line, 1'b0);
		end_test();

		repeat (4) @(negedge clk);
		$display("Tests run: %0d, failed: %0d, checks: %0d, errors: %0d",
			tests_run, tests_failed, checks, total_errors());
		if (total_errors() == 0 && tests_failed == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

//--- memory_accessors.f
+incdir+include
verilog/pkg_cpu_types.sv
verilog/pkg_mem_bus.sv
verilog/instr_cache.sv
verilog/lar_file.sv
verilog/mem_bus_guard.sv
verilog/memory_accessors.sv
sim/memory_accessors_tb.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST ?= memory_accessors.f
TB_TOP ?= memory_accessors_tb
RTL_TOP ?= memory_accessors
BUILD_DIR ?= obj_dir
VFLAGS ?= --timing --assert --timescale 1ns/1ps
PASS_TEXT ?= Simulation PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
